// File: hdl/peak_consts.svh
`ifndef PEAK_CONSTS_SVH
`define PEAK_CONSTS_SVH

// Signed I and Q width.
`define PEAK_SAMPLE_W 16

// Unsigned power width, I*I + Q*Q fits without saturation.
`define PEAK_POWER_W 32

// Average window, power of two.
`define PEAK_WINDOW_LEN 8

// Sample index and frame length width.
`define PEAK_INDEX_W 16

`endif

// File: hdl/peak_pkg.sv
`include "peak_consts.svh"

package peak_pkg;

    typedef struct packed {
        logic signed [`PEAK_SAMPLE_W-1:0] i;
        logic signed [`PEAK_SAMPLE_W-1:0] q;
    } iq_sample_t;

    typedef struct packed {
        logic                     detected;
        logic [`PEAK_POWER_W-1:0] score;    // Power above threshold.
    } detect_result_t;

    typedef struct packed {
        logic                     found;
        logic [`PEAK_POWER_W-1:0] best_score;
        logic [`PEAK_INDEX_W-1:0] best_index; // First index with best score.
    } frame_report_t;

endpackage

// File: hdl/power_calc.sv
`timescale 1ns/100ps
`include "peak_consts.svh"

module power_calc (
    input  logic                     clk_i,
    input  logic                     reset_ni,
    input  logic                     iq_valid_i,
    input  peak_pkg::iq_sample_t     iq_i,
    output logic                     power_valid_o,
    output logic [`PEAK_POWER_W-1:0] power_o
);

    logic signed [2*`PEAK_SAMPLE_W-1:0] i_sq;
    logic signed [2*`PEAK_SAMPLE_W-1:0] q_sq;
    logic        [`PEAK_POWER_W-1:0]    power_d;

    assign i_sq = iq_i.i * iq_i.i;
    assign q_sq = iq_i.q * iq_i.q;

    // Both squares are non-negative, the sum is read as unsigned.
    assign power_d = $unsigned(i_sq) + $unsigned(q_sq);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            power_valid_o <= 1'b0;
        end else begin
            power_valid_o <= iq_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (iq_valid_i) begin
            power_o <= power_d;  // Payload only.
        end
    end

    a_power_latency: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        1'b1 |=> (power_valid_o == $past(iq_valid_i))
    ) else $error("power_valid_o does not follow iq_valid_i by one cycle");

endmodule

// File: hdl/peak_detector.sv
`timescale 1ns/100ps
`include "peak_consts.svh"

module peak_detector (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      power_valid_i,
    input  logic [`PEAK_POWER_W-1:0]  power_i,
    input  logic [`PEAK_POWER_W-1:0]  noise_limit_i,
    input  logic [7:0]                detection_shift_i,
    output logic                      result_valid_o,
    output peak_pkg::detect_result_t  result_o
);

    import peak_pkg::*;

    localparam int LOG2_LEN = $clog2(`PEAK_WINDOW_LEN);
    localparam int SUM_W    = `PEAK_POWER_W + LOG2_LEN;
    // Room for a left shift of the sum up to the power width.
    localparam int THR_W    = SUM_W + `PEAK_POWER_W;

    logic [`PEAK_POWER_W-1:0] window_q [`PEAK_WINDOW_LEN];
    logic [SUM_W-1:0]         window_sum;
    logic [LOG2_LEN:0]        warm_cnt;
    logic                     warm_done;
    logic signed [9:0]        total_shift;
    logic [9:0]               left_shift;
    logic [THR_W-1:0]         threshold;
    logic [THR_W-1:0]         power_ext;
    detect_result_t           result_d;

    assign warm_done   = (warm_cnt == (LOG2_LEN + 1)'(`PEAK_WINDOW_LEN));
    assign total_shift = 10'(LOG2_LEN) - $signed({2'b00, detection_shift_i});
    assign power_ext   = THR_W'(power_i);

    always_comb begin
        left_shift = 10'(-total_shift);
        // Beyond this any nonzero sum already exceeds every power.
        if (left_shift > 10'(`PEAK_POWER_W)) begin
            left_shift = 10'(`PEAK_POWER_W);
        end
        if (total_shift >= 0) begin
            threshold = THR_W'(window_sum >> $unsigned(total_shift));
        end else begin
            threshold = THR_W'(window_sum) << left_shift;
        end
    end

    always_comb begin
        result_d.detected = (power_ext > threshold) && (power_i > noise_limit_i);
        if (result_d.detected) begin
            result_d.score = `PEAK_POWER_W'(power_ext - threshold);
        end else begin
            result_d.score = '0;
        end
    end

    // Window of preceding powers and their running sum.
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int k = 0; k < `PEAK_WINDOW_LEN; k++) begin
                window_q[k] <= '0;
            end
            window_sum <= '0;
            warm_cnt   <= '0;
        end else if (power_valid_i) begin
            window_q[0] <= power_i;
            for (int k = 1; k < `PEAK_WINDOW_LEN; k++) begin
                window_q[k] <= window_q[k-1];
            end
            window_sum <= window_sum + SUM_W'(power_i)
                          - SUM_W'(window_q[`PEAK_WINDOW_LEN-1]); // Drop oldest.
            if (!warm_done) begin
                warm_cnt <= warm_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= power_valid_i && warm_done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (power_valid_i) begin
            result_o <= result_d;
        end
    end

    a_no_result_in_warmup: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        !warm_done |=> !result_valid_o
    ) else $error("result_valid_o raised during warm-up");

    // A detection always leaves a nonzero margin over the threshold.
    a_score_needs_detect: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        result_valid_o |-> (result_o.detected == (result_o.score != '0))
    ) else $error("score and detected flag disagree");

endmodule

// File: hdl/peak_tracker.sv
`timescale 1ns/100ps
`include "peak_consts.svh"

module peak_tracker (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      result_valid_i,
    input  peak_pkg::detect_result_t  result_i,
    input  logic [`PEAK_INDEX_W-1:0]  frame_len_i,
    output logic                      report_valid_o,
    output peak_pkg::frame_report_t   report_o
);

    import peak_pkg::*;

    logic [`PEAK_INDEX_W-1:0] index_q;
    logic                     found_q;
    logic [`PEAK_POWER_W-1:0] best_score_q;
    logic [`PEAK_INDEX_W-1:0] best_index_q;
    logic                     last_in_frame;
    logic                     new_best;
    frame_report_t            report_d;

    assign last_in_frame = (index_q == frame_len_i - 1'b1);

    // Strictly greater keeps the first index that reached the best score.
    assign new_best = (result_i.score > best_score_q);

    // Running state with the current result folded in.
    always_comb begin
        report_d.found = found_q | result_i.detected;
        if (new_best) begin
            report_d.best_score = result_i.score;
            report_d.best_index = index_q;
        end else begin
            report_d.best_score = best_score_q;
            report_d.best_index = best_index_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            index_q        <= '0;
            found_q        <= 1'b0;
            best_score_q   <= '0;
            best_index_q   <= '0;
            report_valid_o <= 1'b0;
        end else begin
            report_valid_o <= result_valid_i && last_in_frame;
            if (result_valid_i) begin
                if (last_in_frame) begin
                    index_q      <= '0;  // Next frame starts clean.
                    found_q      <= 1'b0;
                    best_score_q <= '0;
                    best_index_q <= '0;
                end else begin
                    index_q      <= index_q + 1'b1;
                    found_q      <= report_d.found;
                    best_score_q <= report_d.best_score;
                    best_index_q <= report_d.best_index;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (result_valid_i && last_in_frame) begin
            report_o <= report_d;
        end
    end

    // Frames of one sample may report on every cycle.
    a_report_pulse: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (report_valid_o && (frame_len_i > `PEAK_INDEX_W'(1))) |=> !report_valid_o
    ) else $error("report_valid_o held longer than one cycle");

endmodule

// File: hdl/peak_search_top.sv
`timescale 1ns/100ps
`include "peak_consts.svh"

module peak_search_top (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      iq_valid_i,
    input  peak_pkg::iq_sample_t      iq_i,
    input  logic [`PEAK_POWER_W-1:0]  noise_limit_i,
    input  logic [7:0]                detection_shift_i,
    input  logic [`PEAK_INDEX_W-1:0]  frame_len_i,
    output logic                      result_valid_o,
    output peak_pkg::detect_result_t  result_o,
    output logic                      report_valid_o,
    output peak_pkg::frame_report_t   report_o
);

    logic                     power_valid;
    logic [`PEAK_POWER_W-1:0] power;

    power_calc u_power_calc (
        .clk_i         (clk_i),
        .reset_ni      (reset_ni),
        .iq_valid_i    (iq_valid_i),
        .iq_i          (iq_i),
        .power_valid_o (power_valid),
        .power_o       (power)
    );

    peak_detector u_peak_detector (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .power_valid_i     (power_valid),
        .power_i           (power),
        .noise_limit_i     (noise_limit_i),
        .detection_shift_i (detection_shift_i),
        .result_valid_o    (result_valid_o),
        .result_o          (result_o)
    );

    // Fed from the exposed detector outputs.
    peak_tracker u_peak_tracker (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .result_valid_i (result_valid_o),
        .result_i       (result_o),
        .frame_len_i    (frame_len_i),
        .report_valid_o (report_valid_o),
        .report_o       (report_o)
    );

endmodule

// File: verif/peak_search_tb.sv
`timescale 1ns/100ps
`include "peak_consts.svh"

module peak_search_tb;

    import peak_pkg::*;

    localparam int LOG2_WIN     = $clog2(`PEAK_WINDOW_LEN);
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 6;   // Covers the three-cycle report latency.
    localparam int NUM_TESTS    = 6;

    localparam int CYC_WARMUP   = 40;
    localparam int CYC_SHIFT_LO = 240;
    localparam int CYC_SHIFT_HI = 240;
    localparam int CYC_NOISE    = 160;
    localparam int CYC_QUIET    = 48;
    localparam int CYC_B2B      = 120;

    localparam int TOTAL_CYCLES = CYC_WARMUP + CYC_SHIFT_LO + CYC_SHIFT_HI + CYC_NOISE
                                  + CYC_QUIET + CYC_B2B
                                  + NUM_TESTS * (1 + RESET_CYCLES + DRAIN_CYCLES);
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_CYCLES + 100;

    // Expected DUT outputs for one driven sample.
    typedef struct packed {
        logic           res_valid;
        detect_result_t res;
        logic           rep_valid;
        frame_report_t  rep;
    } expect_t;

    logic                     clk_i = 1'b0;
    logic                     reset_ni;
    logic                     iq_valid_i;
    iq_sample_t               iq_i;
    logic [`PEAK_POWER_W-1:0] noise_limit_i;
    logic [7:0]               detection_shift_i;
    logic [`PEAK_INDEX_W-1:0] frame_len_i;
    logic                     result_valid_o;
    detect_result_t           result_o;
    logic                     report_valid_o;
    frame_report_t            report_o;

    expect_t cur_exp;
    expect_t exp_d1;
    expect_t exp_d2;
    expect_t exp_d3;
    bit      expect_quiet;

    logic [`PEAK_POWER_W-1:0] win_q [$];   // Preceding powers, oldest first.
    int                       m_index;
    logic                     m_found;
    logic [`PEAK_POWER_W-1:0] m_best;
    logic [`PEAK_INDEX_W-1:0] m_best_idx;
    int                       n_results;
    int                       n_detects;
    int                       n_reports;

    string test_name;
    int    test_errors;
    int    total_errors = 0;
    int    failed_tests = 0;
    int    cycle_cnt = 0;

    peak_search_top u_peak_search_top (
        .clk_i             (clk_i),
        .reset_ni          (reset_ni),
        .iq_valid_i        (iq_valid_i),
        .iq_i              (iq_i),
        .noise_limit_i     (noise_limit_i),
        .detection_shift_i (detection_shift_i),
        .frame_len_i       (frame_len_i),
        .result_valid_o    (result_valid_o),
        .result_o          (result_o),
        .report_valid_o    (report_valid_o),
        .report_o          (report_o)
    );

    always #4 clk_i = ~clk_i;

    // Expected values delayed to the DUT output cycles.
    always @(posedge clk_i) begin
        if (!reset_ni) begin
            exp_d1 <= '0;
            exp_d2 <= '0;
            exp_d3 <= '0;
        end else begin
            exp_d1 <= cur_exp;
            exp_d2 <= exp_d1;
            exp_d3 <= exp_d2;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic void log_mismatch(input string what, input logic [63:0] exp_val,
                                         input logic [63:0] act_val);
        test_errors++;
        total_errors++;
        $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what,
                 exp_val, act_val);
    endfunction

    function automatic void model_clear();
        win_q.delete();
        m_index    = 0;
        m_found    = 1'b0;
        m_best     = '0;
        m_best_idx = '0;
        n_results  = 0;
        n_detects  = 0;
        n_reports  = 0;
    endfunction

    // Power, window threshold and frame tracking for one strobed sample.
    function automatic expect_t model_sample(input iq_sample_t s);
        longint unsigned pwr;
        longint unsigned sum;
        longint unsigned thr;
        int              shift_amt;
        expect_t         e;
        e   = '0;
        pwr = longint'(s.i) * longint'(s.i) + longint'(s.q) * longint'(s.q);
        if (win_q.size() == `PEAK_WINDOW_LEN) begin
            sum = 0;
            foreach (win_q[k]) begin
                sum += win_q[k];
            end
            shift_amt = LOG2_WIN - int'(detection_shift_i);
            if (shift_amt >= 0) begin
                thr = sum >> shift_amt;
            end else begin
                thr = sum << (-shift_amt);
            end
            e.res_valid    = 1'b1;
            e.res.detected = (pwr > thr) && (pwr > noise_limit_i);
            if (e.res.detected) begin
                e.res.score = `PEAK_POWER_W'(pwr - thr);
                n_detects++;
            end
            n_results++;
            m_found = m_found | e.res.detected;
            if (e.res.score > m_best) begin
                m_best     = e.res.score;
                m_best_idx = `PEAK_INDEX_W'(m_index);
            end
            if (m_index == int'(frame_len_i) - 1) begin
                e.rep_valid      = 1'b1;
                e.rep.found      = m_found;
                e.rep.best_score = m_best;
                e.rep.best_index = m_best_idx;
                n_reports++;
                m_index    = 0;
                m_found    = 1'b0;
                m_best     = '0;
                m_best_idx = '0;
            end else begin
                m_index++;
            end
        end
        win_q.push_back(`PEAK_POWER_W'(pwr));
        if (win_q.size() > `PEAK_WINDOW_LEN) begin
            void'(win_q.pop_front());
        end
        return e;
    endfunction

    function automatic iq_sample_t random_sample(input int amp);
        iq_sample_t s;
        s.i = `PEAK_SAMPLE_W'(int'($urandom_range(2 * amp)) - amp);
        s.q = `PEAK_SAMPLE_W'(int'($urandom_range(2 * amp)) - amp);
        return s;
    endfunction

    task automatic step_cycle(input bit valid, input iq_sample_t s);
        expect_t e;
        e = '0;
        @(posedge clk_i);
        if (valid) begin
            e = model_sample(s);
        end
        iq_valid_i <= valid;
        iq_i       <= s;
        cur_exp    <= e;
    endtask

    task automatic run_test(input string name, input logic [`PEAK_POWER_W-1:0] noise,
                            input logic [7:0] shift, input logic [`PEAK_INDEX_W-1:0] frame_len,
                            input bit quiet, input int cycles, input int gap_pct,
                            input int burst_pct, input int quiet_amp, input int burst_amp);
        int amp;
        bit valid;
        test_name   = name;
        test_errors = 0;
        @(posedge clk_i);
        reset_ni          <= 1'b0;
        iq_valid_i        <= 1'b0;
        cur_exp           <= '0;
        noise_limit_i     <= noise;
        detection_shift_i <= shift;
        frame_len_i       <= frame_len;
        expect_quiet      <= quiet;
        model_clear();
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_ni <= 1'b1;
        for (int c = 0; c < cycles; c++) begin
            valid = ($urandom_range(99) >= gap_pct);
            amp   = ($urandom_range(99) < burst_pct) ? burst_amp : quiet_amp;
            step_cycle(valid, random_sample(amp));
        end
        repeat (DRAIN_CYCLES) step_cycle(1'b0, '0);
        if (test_errors == 0) begin
            $display("Test %s ok: %0d results, %0d detected, %0d reports", test_name,
                     n_results, n_detects, n_reports);
        end else begin
            failed_tests++;
            $display("Test %s FAIL: %0d errors", test_name, test_errors);
        end
    endtask

    a_result_valid: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        result_valid_o == exp_d2.res_valid
    ) else log_mismatch("result_valid_o", 64'($sampled(exp_d2.res_valid)),
                        64'($sampled(result_valid_o)));

    a_result_value: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        result_valid_o |-> (result_o == exp_d2.res)
    ) else log_mismatch("result_o", 64'($sampled(exp_d2.res)), 64'($sampled(result_o)));

    a_report_valid: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        report_valid_o == exp_d3.rep_valid
    ) else log_mismatch("report_valid_o", 64'($sampled(exp_d3.rep_valid)),
                        64'($sampled(report_valid_o)));

    a_report_value: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        report_valid_o |-> (report_o == exp_d3.rep)
    ) else log_mismatch("report_o", 64'($sampled(exp_d3.rep)), 64'($sampled(report_o)));

    // Nothing may be flagged while every power stays under the noise floor.
    a_quiet_result: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (expect_quiet && result_valid_o) |-> !result_o.detected
    ) else log_mismatch("result_o.detected", 64'(0), 64'($sampled(result_o.detected)));

    a_quiet_report: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (expect_quiet && report_valid_o) |-> (report_o == '0)
    ) else log_mismatch("quiet report_o", 64'(0), 64'($sampled(report_o)));

    initial begin
        void'($urandom(32'h5029_57c9));
        reset_ni          <= 1'b0;
        iq_valid_i        <= 1'b0;
        iq_i              <= '0;
        noise_limit_i     <= '0;
        detection_shift_i <= 8'd3;
        frame_len_i       <= `PEAK_INDEX_W'(8);
        cur_exp           <= '0;
        expect_quiet      <= 1'b0;

        run_test("reset_warmup", 32'd0, 8'd3, 16'd8, 1'b0, CYC_WARMUP, 30, 10, 300, 32767);
        run_test("shift_below", 32'd1000, 8'd1, 16'd20, 1'b0, CYC_SHIFT_LO, 25, 6, 300, 32767);
        run_test("shift_above", 32'd1000, 8'd5, 16'd20, 1'b0, CYC_SHIFT_HI, 25, 6, 300, 32767);
        run_test("noise_floor", 32'hFFFF_FFFF, 8'd0, 16'd16, 1'b1, CYC_NOISE, 20, 15, 300,
                 32767);
        run_test("quiet_frame", 32'd100, 8'd3, 16'd12, 1'b1, CYC_QUIET, 0, 0, 3, 3);
        run_test("back_to_back", 32'd500, 8'd2, 16'd4, 1'b0, CYC_B2B, 0, 8, 300, 32767);

        $display("Summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests,
                 total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: peak_search_top.f
+incdir+hdl
hdl/peak_pkg.sv
hdl/power_calc.sv
hdl/peak_detector.sv
hdl/peak_tracker.sv
hdl/peak_search_top.sv
verif/peak_search_tb.sv

// File: Bender.yml
package:
  name: peak_search

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/peak_pkg.sv
      - hdl/power_calc.sv
      - hdl/peak_detector.sv
      - hdl/peak_tracker.sv
      - hdl/peak_search_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/peak_search_tb.sv
